// File: Makefile
TB = tb_enemy_wave

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f enemy_wave.f --top-module enemy_wave

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --timescale 1ns/1ps -f enemy_wave.f --top-module $(TB)
	./obj_dir/V$(TB) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: enemy_wave.f
src/vga_pkg.sv
src/enemy_pkg.sv
src/vga_timing.sv
src/enemy_slot.sv
src/video_out.sv
src/enemy_wave.sv
sim/tb_enemy_wave.sv

// File: sim/tb_enemy_wave.sv
/* testbench for the enemy wave. every output pixel is compared with a
   frame-stepped model of the enemies while the stimulus fires shots
   and a level change */
module tb_enemy_wave;
  timeunit 1ns;
  timeprecision 1ps;
  import vga_pkg::*;
  import enemy_pkg::*;

  localparam int     LATENCY     = N_ENEMY + 2;
  localparam int     MAX_MSGS    = 50;
  localparam int     KILL_STEP   = 5;   // slot 2 is gone from this frame on
  localparam int     REVIVE_STEP = 9;   // level change lands here
  localparam coord_t MIS_OFS     = 11'd14;  // missile x relative to the box
  localparam int     TIMEOUT_CYC = 12 * int'(V_TOTAL) * int'(H_TOTAL) + 20000;

  logic       pclk = 1'b0;
  logic       rst_n_i;
  shot_t      shot_i;
  logic       level_change_i;
  pix_t       pix_o;
  enemy_cnt_t lives_o;

  integer seed = 32'h6caf;
  int     cyc = 0;
  int     steps = 0;
  int     checks = 0;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     test_err0 = 0;
  string  test_name = "reset";
  coord_t exp_h = '0;  // raster position the output should show
  coord_t exp_v = '0;

  // enemy model, advanced once per frame
  coord_t m_x      [N_ENEMY];
  logic   m_dir    [N_ENEMY];
  logic   m_alive  [N_ENEMY];
  logic   m_mis_on [N_ENEMY];
  coord_t m_mis_x  [N_ENEMY];
  coord_t m_mis_y  [N_ENEMY];
  logic   m_hit    [N_ENEMY];
  logic   m_lc;

  enemy_wave uut (
    .pclk           (pclk),
    .rst_n_i        (rst_n_i),
    .shot_i         (shot_i),
    .level_change_i (level_change_i),
    .pix_o          (pix_o),
    .lives_o        (lives_o)
  );

  always #2 pclk = ~pclk;

  function automatic coord_t start_x(int k);
    return coord_t'(int'(ENEMY_X0) + k * int'(ENEMY_PITCH));
  endfunction

  function automatic logic in_box(int k, coord_t x, coord_t y);
    return (x >= m_x[k]) && (x <= m_x[k] + ENEMY_W - 11'd1) &&
           (y >= ENEMY_Y) && (y <= ENEMY_Y + ENEMY_H - 11'd1);
  endfunction

  function automatic logic in_any_box(coord_t x, coord_t y);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < N_ENEMY; k++) begin
      hit = hit | in_box(k, x, y);
    end
    return hit;
  endfunction

  // expected colour, later slots paint over earlier ones
  function automatic rgb_t exp_rgb(coord_t h, coord_t v);
    rgb_t c;
    if (h >= H_VISIBLE || v >= V_VISIBLE) begin
      return '0;
    end
    c = BG_RGB;
    for (int k = 0; k < N_ENEMY; k++) begin
      if (m_mis_on[k] && h >= m_mis_x[k] && h < m_mis_x[k] + MIS_W &&
          v >= m_mis_y[k] && v < m_mis_y[k] + MIS_H) begin
        c = MIS_RGB;
      end else if (m_alive[k] && in_box(k, h, v)) begin
        c = ENEMY_RGB;
      end
    end
    return c;
  endfunction

  // {hsync, vsync, hblnk, vblnk}
  function automatic logic [3:0] exp_flags(coord_t h, coord_t v);
    logic hs;
    logic vs;
    hs = !(h >= H_VISIBLE + H_FRONT && h < H_VISIBLE + H_FRONT + H_SYNC);
    vs = !(v >= V_VISIBLE + V_FRONT && v < V_VISIBLE + V_FRONT + V_SYNC);
    return {hs, vs, h >= H_VISIBLE, v >= V_VISIBLE};
  endfunction

  function automatic enemy_cnt_t exp_lives();
    enemy_cnt_t n;
    n = '0;
    for (int k = 0; k < N_ENEMY; k++) begin
      if (m_alive[k]) begin
        n = n + 3'd1;
      end
    end
    return n;
  endfunction

  task automatic model_reset();
    for (int k = 0; k < N_ENEMY; k++) begin
      m_x[k]      = start_x(k);
      m_dir[k]    = 1'b1;
      m_alive[k]  = 1'b1;
      m_mis_on[k] = 1'b0;
      m_mis_x[k]  = '0;
      m_mis_y[k]  = '0;
      m_hit[k]    = 1'b0;
    end
    m_lc = 1'b0;
  endtask

  // frame update: level change, then hit, then motion, then missile
  task automatic step_model();
    logic alive_new;
    for (int k = 0; k < N_ENEMY; k++) begin
      if (m_lc) begin
        m_alive[k]  = 1'b1;
        m_x[k]      = start_x(k);
        m_dir[k]    = 1'b1;
        m_mis_on[k] = 1'b0;
      end else begin
        alive_new = m_alive[k] & ~m_hit[k];
        if (alive_new) begin
          m_x[k] = m_dir[k] ? m_x[k] + 11'd1 : m_x[k] - 11'd1;
          if (m_x[k] == X_MAX) begin
            m_dir[k] = 1'b0;
          end else if (m_x[k] == X_MIN) begin
            m_dir[k] = 1'b1;
          end
        end
        m_alive[k] = alive_new;
        if (m_mis_on[k]) begin
          m_mis_y[k] = m_mis_y[k] + MIS_STEP;
          if (m_mis_y[k] > V_VISIBLE) begin
            m_mis_on[k] = 1'b0;
          end
        end else if (alive_new) begin
          m_mis_on[k] = 1'b1;
          m_mis_x[k]  = m_x[k] + MIS_OFS;
          m_mis_y[k]  = ENEMY_Y + ENEMY_H;
        end
      end
      m_hit[k] = 1'b0;
    end
    m_lc = 1'b0;
  endtask

  task automatic log_mismatch(string field, string want_s, string got_s);
    errors++;
    if (errors <= MAX_MSGS) begin
      $display("FAIL %s: %s at %0d,%0d expected %s, got %s",
               test_name, field, exp_h, exp_v, want_s, got_s);
    end else if (errors == MAX_MSGS + 1) begin
      $display("more mismatches follow, only counted from here on");
    end
  endtask

  task automatic check_rgb(rgb_t want, rgb_t got);
    checks++;
    if (got !== want) begin
      log_mismatch("rgb", $sformatf("%h", want), $sformatf("%h", got));
    end
  endtask

  task automatic check_lives(enemy_cnt_t want, enemy_cnt_t got);
    checks++;
    if (got !== want) begin
      log_mismatch("lives", $sformatf("%0d", want), $sformatf("%0d", got));
    end
  endtask

  task automatic check_count(string field, coord_t want, coord_t got);
    checks++;
    if (got !== want) begin
      log_mismatch(field, $sformatf("%0d", want), $sformatf("%0d", got));
    end
  endtask

  task automatic check_flags(logic [3:0] want, logic [3:0] got);
    checks++;
    if (got !== want) begin
      log_mismatch("syncs/blanks", $sformatf("%b", want), $sformatf("%b", got));
    end
  endtask

  // compare process, outputs are stable at the falling edge
  always @(negedge pclk) begin
    if (!rst_n_i) begin
      model_reset();
    end else if (cyc >= LATENCY) begin
      check_count("hcount", exp_h, pix_o.hcount);
      check_count("vcount", exp_v, pix_o.vcount);
      check_flags(exp_flags(exp_h, exp_v), {pix_o.hsync, pix_o.vsync, pix_o.hblnk, pix_o.vblnk});
      check_rgb(exp_rgb(exp_h, exp_v), pix_o.rgb);
      if (exp_h < H_VISIBLE && exp_v < V_VISIBLE) begin
        check_lives(exp_lives(), lives_o);
      end
      if (exp_h == '0 && exp_v == 11'd100 && steps >= KILL_STEP) begin
        // kill and revive counts straight from the stimulus schedule
        check_lives(enemy_cnt_t'(steps < REVIVE_STEP ? N_ENEMY - 1 : N_ENEMY), lives_o);
      end
      if (exp_h == '0 && exp_v == V_VISIBLE) begin
        step_model();
        steps++;
      end
      if (level_change_i) begin
        m_lc = 1'b1;
      end
      if (shot_i.on) begin
        for (int k = 0; k < N_ENEMY; k++) begin
          if (m_alive[k] && in_box(k, shot_i.x, shot_i.y)) begin
            m_hit[k] = 1'b1;
          end
        end
      end
      if (exp_h == H_TOTAL - 11'd1) begin
        exp_h = '0;
        exp_v = (exp_v == V_TOTAL - 11'd1) ? '0 : exp_v + 11'd1;
      end else begin
        exp_h = exp_h + 11'd1;
      end
    end
  end

  always @(posedge pclk) begin
    if (rst_n_i) begin
      cyc++;
      if (cyc > TIMEOUT_CYC) begin
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYC);
        $display("Result: FAILED");
        $finish;
      end
    end
  end

  task automatic wait_steps(int n);
    while (steps < n) begin
      @(posedge pclk);
    end
  endtask

  task automatic wait_line(coord_t v);
    while (exp_v != v) begin
      @(posedge pclk);
    end
  endtask

  task automatic fire(coord_t x, coord_t y, int hold);
    shot_i <= '{x: x, y: y, on: 1'b1};
    repeat (hold) @(posedge pclk);
    shot_i <= '0;
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic finish_test();
    int n;
    n = errors - test_err0;
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", test_name, n);
    end
  endtask

  initial begin
    coord_t rx;
    coord_t ry;
    rst_n_i        = 1'b0;
    shot_i         = '0;
    level_change_i = 1'b0;
    repeat (3) @(posedge pclk);
    rst_n_i <= 1'b1;

    start_test("first_frame");
    wait_steps(1);
    finish_test();
    start_test("raster_wrap");
    wait_steps(2);
    finish_test();
    start_test("motion");
    wait_steps(KILL_STEP - 1);
    finish_test();

    start_test("shot_kill");
    wait_line(11'd200);
    fire(m_x[2] + ENEMY_W / 2, ENEMY_Y + ENEMY_H / 2, 4);  // middle of slot 2
    wait_steps(KILL_STEP + 1);
    finish_test();

    start_test("random_miss");
    wait_line(11'd200);
    for (int i = 0; i < 24; i++) begin
      do begin
        rx = coord_t'({$random(seed)} % int'(H_VISIBLE));
        ry = coord_t'({$random(seed)} % int'(V_VISIBLE));
      end while (in_any_box(rx, ry));
      fire(rx, ry, 2);
    end
    wait_steps(REVIVE_STEP - 1);
    finish_test();

    start_test("level_change");
    wait_line(11'd300);
    level_change_i <= 1'b1;
    @(posedge pclk);
    level_change_i <= 1'b0;
    wait_steps(REVIVE_STEP + 1);
    finish_test();

    $display("tests: %0d run, %0d failed; checks: %0d, mismatches: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: src/enemy_pkg.sv
/* enemy wave layout, colours, motion steps and the types that the
   enemy slots exchange with the top level */
package enemy_pkg;
  import vga_pkg::*;

  localparam int N_ENEMY = 4;

  // enemy box
  localparam coord_t ENEMY_W     = 11'd32;
  localparam coord_t ENEMY_H     = 11'd24;
  localparam coord_t ENEMY_Y     = 11'd80;   // row all enemies fly along
  localparam coord_t ENEMY_X0    = 11'd100;  // start x of slot 0
  localparam coord_t ENEMY_PITCH = 11'd150;

  // travel limits for the left edge of the box
  localparam coord_t X_MIN = 11'd20;
  localparam coord_t X_MAX = 11'd748;

  // enemy missile
  localparam coord_t MIS_W    = 11'd4;
  localparam coord_t MIS_H    = 11'd12;
  localparam coord_t MIS_STEP = 11'd6;  // fall per frame
  localparam coord_t MIS_DX   = (ENEMY_W - MIS_W) / 2;  // centred under the box

  localparam rgb_t ENEMY_RGB = 12'h0e2;
  localparam rgb_t MIS_RGB   = 12'hf80;

  typedef logic [2:0]         enemy_cnt_t;
  typedef logic [N_ENEMY-1:0] alive_t;
  typedef logic [1:0]         slot_idx_t;

  // tip of the player missile
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   on;
  } shot_t;

endpackage

// File: src/enemy_slot.sv
/* one enemy of the wave with its missile. state changes once per frame,
   at the first pixel of vertical blanking, and is painted over the
   passing pixel stream with one clock of latency */
module enemy_slot (
  input  logic                 pclk,
  input  logic                 rst_n_i,
  input  enemy_pkg::slot_idx_t slot_i,
  input  vga_pkg::pix_t        pix_i,
  input  enemy_pkg::shot_t     shot_i,
  input  logic                 level_change_i,
  output vga_pkg::pix_t        pix_o,
  output logic                 alive_o
);
  import vga_pkg::*;
  import enemy_pkg::*;

  coord_t x_q;         // left edge of the box
  logic   dir_q;       // 1 moves right
  logic   alive_q;
  logic   mis_on_q;
  coord_t mis_x_q;
  coord_t mis_y_q;
  logic   lc_pend_q;   // level change seen this frame
  logic   hit_pend_q;  // shot landed this frame

  coord_t start_x;
  logic   frame_upd;
  logic   shot_in_box;
  logic   lc_seen;
  logic   hit_seen;
  logic   alive_new;
  coord_t x_new;
  coord_t mis_y_step;
  logic   visible;
  logic   in_enemy;
  logic   in_mis;
  pix_t   pix_d;

  assign start_x = ENEMY_X0 + ENEMY_PITCH * coord_t'(slot_i);

  // first pixel of vertical blanking
  assign frame_upd = (pix_i.hcount == '0) && (pix_i.vcount == V_VISIBLE);

  assign shot_in_box = shot_i.on &&
                       (shot_i.x >= x_q) && (shot_i.x <= x_q + ENEMY_W - 11'd1) &&
                       (shot_i.y >= ENEMY_Y) && (shot_i.y <= ENEMY_Y + ENEMY_H - 11'd1);

  // include events arriving on the update clock itself
  assign lc_seen  = lc_pend_q | level_change_i;
  assign hit_seen = hit_pend_q | (alive_q & shot_in_box);

  always_comb begin
    alive_new  = alive_q & ~hit_seen;
    x_new      = x_q;
    mis_y_step = mis_y_q + MIS_STEP;
    if (alive_new) begin
      if (dir_q) begin
        x_new = x_q + 11'd1;
      end else begin
        x_new = x_q - 11'd1;
      end
    end
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      x_q        <= start_x;
      dir_q      <= 1'b1;
      alive_q    <= 1'b1;
      mis_on_q   <= 1'b0;
      mis_x_q    <= '0;
      mis_y_q    <= '0;
      lc_pend_q  <= 1'b0;
      hit_pend_q <= 1'b0;
    end else if (frame_upd) begin
      lc_pend_q  <= 1'b0;
      hit_pend_q <= 1'b0;
      if (lc_seen) begin
        // new level: back to the start, missile gone
        alive_q  <= 1'b1;
        x_q      <= start_x;
        dir_q    <= 1'b1;
        mis_on_q <= 1'b0;
      end else begin
        alive_q <= alive_new;
        x_q     <= x_new;
        if (alive_new) begin
          if (x_new == X_MAX) begin
            dir_q <= 1'b0;
          end else if (x_new == X_MIN) begin
            dir_q <= 1'b1;
          end
        end
        // a missile in flight keeps falling even if its enemy died
        if (mis_on_q) begin
          mis_y_q <= mis_y_step;
          if (mis_y_step > V_VISIBLE) begin
            mis_on_q <= 1'b0;
          end
        end else if (alive_new) begin
          mis_on_q <= 1'b1;
          mis_x_q  <= x_new + MIS_DX;
          mis_y_q  <= ENEMY_Y + ENEMY_H;  // just below the box
        end
      end
    end else begin
      if (level_change_i) begin
        lc_pend_q <= 1'b1;
      end
      if (alive_q && shot_in_box) begin
        hit_pend_q <= 1'b1;
      end
    end
  end

  // drawing, missile over enemy over incoming colour
  always_comb begin
    visible  = ~pix_i.hblnk & ~pix_i.vblnk;
    in_mis   = mis_on_q &&
               (pix_i.hcount >= mis_x_q) && (pix_i.hcount <= mis_x_q + MIS_W - 11'd1) &&
               (pix_i.vcount >= mis_y_q) && (pix_i.vcount <= mis_y_q + MIS_H - 11'd1);
    in_enemy = alive_q &&
               (pix_i.hcount >= x_q) && (pix_i.hcount <= x_q + ENEMY_W - 11'd1) &&
               (pix_i.vcount >= ENEMY_Y) && (pix_i.vcount <= ENEMY_Y + ENEMY_H - 11'd1);
    pix_d = pix_i;
    if (visible && in_mis) begin
      pix_d.rgb = MIS_RGB;
    end else if (visible && in_enemy) begin
      pix_d.rgb = ENEMY_RGB;
    end
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_o <= PIX_RST;
    end else begin
      pix_o <= pix_d;
    end
  end

  assign alive_o = alive_q;

endmodule

// File: src/enemy_wave.sv
/* enemy layer of the shooter. raster generator feeds a chain of enemy
   slots, each adding one enemy and its missile, then the output stage.
   raster to output latency is N_ENEMY + 2 clocks */
module enemy_wave (
  input  logic                  pclk,
  input  logic                  rst_n_i,
  input  enemy_pkg::shot_t      shot_i,
  input  logic                  level_change_i,
  output vga_pkg::pix_t         pix_o,
  output enemy_pkg::enemy_cnt_t lives_o
);
  import vga_pkg::*;
  import enemy_pkg::*;

  pix_t   pix_chain [0:N_ENEMY];  // slot k reads k, drives k+1
  alive_t alive;

  vga_timing u_vga_timing (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .pix_o   (pix_chain[0])
  );

  for (genvar k = 0; k < N_ENEMY; k++) begin : g_slot
    enemy_slot u_enemy_slot (
      .pclk           (pclk),
      .rst_n_i        (rst_n_i),
      .slot_i         (slot_idx_t'(k)),  // sets the start x
      .pix_i          (pix_chain[k]),
      .shot_i         (shot_i),
      .level_change_i (level_change_i),
      .pix_o          (pix_chain[k+1]),
      .alive_o        (alive[k])
    );
  end

  video_out u_video_out (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .pix_i   (pix_chain[N_ENEMY]),
    .alive_i (alive),
    .pix_o   (pix_o),
    .lives_o (lives_o)
  );

endmodule

// File: src/vga_pkg.sv
/* raster types and 800x600 timing for the 40 MHz pixel clock,
   shared by every stage of the video pipeline */
package vga_pkg;

  typedef logic [10:0] coord_t;  // pixel or line number
  typedef logic [11:0] rgb_t;    // 4 bits per channel, r in the top nibble

  // horizontal, in pixels
  localparam coord_t H_VISIBLE = 11'd800;
  localparam coord_t H_FRONT   = 11'd40;
  localparam coord_t H_SYNC    = 11'd128;
  localparam coord_t H_TOTAL   = 11'd1056;

  // vertical, in lines
  localparam coord_t V_VISIBLE = 11'd600;
  localparam coord_t V_FRONT   = 11'd1;
  localparam coord_t V_SYNC    = 11'd4;
  localparam coord_t V_TOTAL   = 11'd628;

  localparam rgb_t BG_RGB = 12'h124;  // dark blue sky

  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;  // active low
    logic   vsync;  // active low
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;
  } pix_t;

  // idle pixel held in the pipeline registers during reset
  localparam pix_t PIX_RST = '{hcount: '0, vcount: '0, hsync: 1'b1, vsync: 1'b1,
                               hblnk: 1'b0, vblnk: 1'b0, rgb: '0};

endpackage

// File: src/vga_timing.sv
/* raster generator for 800x600. free-running counters give syncs,
   blank flags and the background colour as one registered pixel
   stream, starting at 0,0 one clock after reset */
module vga_timing (
  input  logic          pclk,
  input  logic          rst_n_i,
  output vga_pkg::pix_t pix_o
);
  import vga_pkg::*;

  coord_t h_cnt_q;
  coord_t v_cnt_q;
  logic   h_last;
  logic   v_last;
  logic   h_sync_win;
  logic   v_sync_win;
  pix_t   pix_d;

  assign h_last = (h_cnt_q == H_TOTAL - 11'd1);
  assign v_last = (v_cnt_q == V_TOTAL - 11'd1);

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else if (h_last) begin
      h_cnt_q <= '0;
      if (v_last) begin
        v_cnt_q <= '0;
      end else begin
        v_cnt_q <= v_cnt_q + 11'd1;
      end
    end else begin
      h_cnt_q <= h_cnt_q + 11'd1;
    end
  end

  // sync windows sit right after the front porch
  assign h_sync_win = (h_cnt_q >= H_VISIBLE + H_FRONT) &&
                      (h_cnt_q <  H_VISIBLE + H_FRONT + H_SYNC);
  assign v_sync_win = (v_cnt_q >= V_VISIBLE + V_FRONT) &&
                      (v_cnt_q <  V_VISIBLE + V_FRONT + V_SYNC);

  always_comb begin
    pix_d.hcount = h_cnt_q;
    pix_d.vcount = v_cnt_q;
    pix_d.hsync  = ~h_sync_win;  // low during the pulse
    pix_d.vsync  = ~v_sync_win;
    pix_d.hblnk  = (h_cnt_q >= H_VISIBLE);
    pix_d.vblnk  = (v_cnt_q >= V_VISIBLE);
    if (pix_d.hblnk || pix_d.vblnk) begin
      pix_d.rgb = '0;
    end else begin
      pix_d.rgb = BG_RGB;
    end
  end

  // one register stage so all fields leave together
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_o <= PIX_RST;
    end else begin
      pix_o <= pix_d;
    end
  end

endmodule

// File: src/video_out.sv
/* last stage before the monitor. clears the colour in blanking,
   registers the stream and reports how many enemies are alive */
module video_out (
  input  logic                  pclk,
  input  logic                  rst_n_i,
  input  vga_pkg::pix_t         pix_i,
  input  enemy_pkg::alive_t     alive_i,
  output vga_pkg::pix_t         pix_o,
  output enemy_pkg::enemy_cnt_t lives_o
);
  import vga_pkg::*;
  import enemy_pkg::*;

  pix_t       pix_d;
  enemy_cnt_t lives_d;

  always_comb begin
    pix_d = pix_i;
    if (pix_i.hblnk || pix_i.vblnk) begin
      pix_d.rgb = '0;  // dac must see black outside the picture
    end
  end

  // population count of the alive mask
  always_comb begin
    lives_d = '0;
    for (int i = 0; i < N_ENEMY; i++) begin
      lives_d = lives_d + enemy_cnt_t'(alive_i[i]);
    end
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_o   <= PIX_RST;
      lives_o <= enemy_cnt_t'(N_ENEMY);  // slots leave reset alive
    end else begin
      pix_o   <= pix_d;
      lives_o <= lives_d;
    end
  end

endmodule
